// ==== logic/wb_bus_pkg.sv ====
// Bus word, address and controller state types for the Wishbone host
// Classic single cycles only, no byte selects
`default_nettype none

package wb_bus_pkg;

    // Data word on both read and write paths
    typedef logic [31:0] wb_data_t;

    // Byte address from the master
    typedef logic [31:0] wb_addr_t;

    // Slave index, taken from address bits 7..4
    typedef logic [3:0] slave_idx_t;

    // Fixed-timing access sequence of the host controller
    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,  // Waiting for cyc and stb
        ST_DECODE   = 2'd1,  // Address settles through decoder
        ST_ACCESS   = 2'd2,  // Outcome registered here
        ST_COMPLETE = 2'd3   // ack or err visible
    } host_state_t;

endpackage

`default_nettype wire

// ==== logic/wb_host_ctrl.sv ====
// Fixed four-state access controller with strobe timeout
// Master must hold its request until ack or err and drop stb right after
`default_nettype none

`include "wb_host_settings.svh"

module wb_host_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cyc_i,
    input  wire                          stb_i,
    input  wire                          we_i,
    input  wire  wb_bus_pkg::wb_data_t   dat_w_i,
    input  wire  wb_bus_pkg::slave_idx_t idx_i,
    input  wire                          bank_hit_i,
    input  wire                          pattern_hit_i,
    input  wire  wb_bus_pkg::wb_data_t   bank_data_i,
    input  wire  wb_bus_pkg::wb_data_t   pattern_word_i,
    output logic                         wr_en_o,
    output       wb_bus_pkg::slave_idx_t wr_idx_o,
    output       wb_bus_pkg::wb_data_t   wr_data_o,
    output       wb_bus_pkg::wb_data_t   dat_r_o,
    output logic                         ack_o,
    output logic                         err_o
);

    localparam int TO_W = $clog2(`WB_TIMEOUT_CYCLES);
    localparam logic [TO_W-1:0] TO_LAST = TO_W'(`WB_TIMEOUT_CYCLES - 1);

    wb_bus_pkg::host_state_t state_q;
    logic [TO_W-1:0]         to_cnt_q;
    logic                    strobe;
    logic                    timeout_hit;

    assign strobe      = cyc_i && stb_i;
    assign timeout_hit = (to_cnt_q == TO_LAST);

    // Counts consecutive strobed cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            to_cnt_q <= '0;
        end else if (strobe) begin
            to_cnt_q <= to_cnt_q + 1'b1;
        end else begin
            to_cnt_q <= '0;
        end
    end

    // Bank write lands on the edge that leaves ACCESS
    assign wr_en_o   = (state_q == wb_bus_pkg::ST_ACCESS) && we_i && bank_hit_i && !timeout_hit;
    assign wr_idx_o  = idx_i;
    assign wr_data_o = dat_w_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= wb_bus_pkg::ST_IDLE;
            dat_r_o <= '0;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
        end else if (timeout_hit) begin
            // Timeout wins over whatever the access would have done
            ack_o   <= 1'b0;
            err_o   <= 1'b1;
            state_q <= wb_bus_pkg::ST_COMPLETE;
        end else begin
            case (state_q)
                wb_bus_pkg::ST_IDLE: begin
                    ack_o <= 1'b0;
                    err_o <= 1'b0;
                    if (strobe) begin
                        state_q <= wb_bus_pkg::ST_DECODE;
                    end
                end
                wb_bus_pkg::ST_DECODE: begin
                    state_q <= wb_bus_pkg::ST_ACCESS;
                end
                wb_bus_pkg::ST_ACCESS: begin
                    if (bank_hit_i) begin
                        if (!we_i) begin
                            dat_r_o <= bank_data_i;
                        end
                        ack_o <= 1'b1;  // Write itself goes through wr_en_o
                    end else if (pattern_hit_i && !we_i) begin
                        dat_r_o <= pattern_word_i;  // Word after two advances
                        ack_o   <= 1'b1;
                    end else begin
                        err_o <= 1'b1;  // Invalid address or pattern write
                    end
                    state_q <= wb_bus_pkg::ST_COMPLETE;
                end
                wb_bus_pkg::ST_COMPLETE: begin
                    ack_o   <= 1'b0;
                    err_o   <= 1'b0;
                    state_q <= wb_bus_pkg::ST_IDLE;
                end
                default: begin
                    state_q <= wb_bus_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/wb_host_settings.svh ====
// Build-time settings for the Wishbone host subsystem
// WB_SLAVE_COUNT must stay between 2 and 15, index 15 is the pattern port
`ifndef WB_HOST_SETTINGS_SVH
`define WB_HOST_SETTINGS_SVH

// Number of bank registers behind the decoder
`define WB_SLAVE_COUNT 8

// Consecutive strobed cycles before err is forced
`define WB_TIMEOUT_CYCLES 16

// Reset value of the 192-bit pattern generator
`define WB_PATTERN_RESET 192'h123456789ABCDEF0_123456789ABCDEF0_123456789ABCDEF0

// Spacing between the reset values of neighbouring bank registers
`define WB_BANK_STRIDE 32'h0000_0200

`endif

// ==== logic/wb_host_top.sv ====
// Wishbone host subsystem, classic single reads and writes from one master
// ack_o and err_o are one-cycle pulses, three edges after the request is seen
`default_nettype none

module wb_host_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  wb_bus_pkg::wb_addr_t adr_i,
    input  wire  wb_bus_pkg::wb_data_t dat_w_i,
    input  wire                        we_i,
    input  wire                        cyc_i,
    input  wire                        stb_i,
    output       wb_bus_pkg::wb_data_t dat_r_o,
    output logic                       ack_o,
    output logic                       err_o
);

    wb_bus_pkg::slave_idx_t idx;
    logic                   bank_hit;
    logic                   pattern_hit;
    wb_bus_pkg::wb_data_t   pattern_word;
    wb_bus_pkg::wb_data_t   bank_data;
    logic                   wr_en;
    wb_bus_pkg::slave_idx_t wr_idx;
    wb_bus_pkg::wb_data_t   wr_data;
    logic                   pattern_adv;

    assign pattern_adv = cyc_i && stb_i;  // Generator steps on every strobed edge

    wb_slave_decoder i_wb_slave_decoder (
        .adr_i         (adr_i),
        .idx_o         (idx),
        .bank_hit_o    (bank_hit),
        .pattern_hit_o (pattern_hit)
    );

    wb_pattern_gen i_wb_pattern_gen (
        .clk    (clk),
        .rst    (rst),
        .adv_i  (pattern_adv),
        .word_o (pattern_word)
    );

    wb_slave_bank i_wb_slave_bank (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data),
        .rd_idx_i  (idx),
        .rd_data_o (bank_data)
    );

    wb_host_ctrl i_wb_host_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cyc_i          (cyc_i),
        .stb_i          (stb_i),
        .we_i           (we_i),
        .dat_w_i        (dat_w_i),
        .idx_i          (idx),
        .bank_hit_i     (bank_hit),
        .pattern_hit_i  (pattern_hit),
        .bank_data_i    (bank_data),
        .pattern_word_i (pattern_word),
        .wr_en_o        (wr_en),
        .wr_idx_o       (wr_idx),
        .wr_data_o      (wr_data),
        .dat_r_o        (dat_r_o),
        .ack_o          (ack_o),
        .err_o          (err_o)
    );

endmodule

`default_nettype wire

// ==== logic/wb_pattern_gen.sv ====
// 192-bit feedback shift register, steps once per strobed cycle
// word_o shows the low 32 bits of the current state
`default_nettype none

`include "wb_host_settings.svh"

module wb_pattern_gen (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        adv_i,
    output       wb_bus_pkg::wb_data_t word_o
);

    wb_pattern_pkg::pattern_t state_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= `WB_PATTERN_RESET;
        end else if (adv_i) begin
            state_q <= wb_pattern_pkg::pattern_step(state_q);
        end
    end

    // Low word feeds the pattern port
    assign word_o = state_q[31:0];

endmodule

`default_nettype wire

// ==== logic/wb_pattern_pkg.sv ====
// Pattern generator state and its one-bit step
// Taps at bits 191, 159 and 127, shifting left
`default_nettype none

package wb_pattern_pkg;

    // Full generator state
    typedef logic [191:0] pattern_t;

    // One shift left with the feedback bit entering at bit 0
    function automatic pattern_t pattern_step(input pattern_t state);
        logic fb;
        fb = state[191] ^ state[159] ^ state[127];
        return {state[190:0], fb};
    endfunction

endpackage

`default_nettype wire

// ==== logic/wb_slave_bank.sv ====
// Bank of WB_SLAVE_COUNT registers, one write port and one async read port
// Reset value of register j is the pattern low word plus j times the stride
`default_nettype none

`include "wb_host_settings.svh"

module wb_slave_bank (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          wr_en_i,
    input  wire  wb_bus_pkg::slave_idx_t wr_idx_i,
    input  wire  wb_bus_pkg::wb_data_t   wr_data_i,
    input  wire  wb_bus_pkg::slave_idx_t rd_idx_i,
    output       wb_bus_pkg::wb_data_t   rd_data_o
);

    localparam int IDX_W = $clog2(`WB_SLAVE_COUNT);
    localparam wb_bus_pkg::slave_idx_t SLAVE_LIMIT =
        wb_bus_pkg::slave_idx_t'(`WB_SLAVE_COUNT);
    localparam wb_pattern_pkg::pattern_t RESET_PATTERN = `WB_PATTERN_RESET;

    wb_bus_pkg::wb_data_t regs_q [`WB_SLAVE_COUNT];

    logic wr_in_range;
    logic rd_in_range;

    assign wr_in_range = (wr_idx_i < SLAVE_LIMIT);
    assign rd_in_range = (rd_idx_i < SLAVE_LIMIT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int j = 0; j < `WB_SLAVE_COUNT; j++) begin
                regs_q[j] <= RESET_PATTERN[31:0] + wb_bus_pkg::wb_data_t'(j) * `WB_BANK_STRIDE;
            end
        end else if (wr_en_i && wr_in_range) begin
            regs_q[wr_idx_i[IDX_W-1:0]] <= wr_data_i;
        end
    end

    // Out-of-range reads return zero, the controller flags them anyway
    always_comb begin
        if (rd_in_range) begin
            rd_data_o = regs_q[rd_idx_i[IDX_W-1:0]];
        end else begin
            rd_data_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wb_slave_decoder.sv ====
// Combinational address decoder, slave index in address bits 7..4
// Any address with bits 31..8 set is invalid
`default_nettype none

`include "wb_host_settings.svh"

module wb_slave_decoder (
    input  wire  wb_bus_pkg::wb_addr_t   adr_i,
    output       wb_bus_pkg::slave_idx_t idx_o,
    output logic                         bank_hit_o,
    output logic                         pattern_hit_o
);

    localparam wb_bus_pkg::slave_idx_t PATTERN_IDX = 4'hF;
    localparam wb_bus_pkg::slave_idx_t SLAVE_LIMIT =
        wb_bus_pkg::slave_idx_t'(`WB_SLAVE_COUNT);

    logic upper_zero;

    assign idx_o      = adr_i[7:4];
    assign upper_zero = (adr_i[31:8] == 24'h0);  // Only the low page is mapped

    always_comb begin
        bank_hit_o    = 1'b0;
        pattern_hit_o = 1'b0;
        if (upper_zero) begin
            if (idx_o < SLAVE_LIMIT) begin
                bank_hit_o = 1'b1;
            end
            if (idx_o == PATTERN_IDX) begin
                pattern_hit_o = 1'b1;  // Read-only pattern port
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Wishbone host testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f sources.f \
    --top-module wb_host_tb \
    -o Vwb_host_tb

./obj_dir/Vwb_host_tb 2>&1 | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== sources.f ====
+incdir+logic
logic/wb_bus_pkg.sv
logic/wb_pattern_pkg.sv
logic/wb_slave_decoder.sv
logic/wb_pattern_gen.sv
logic/wb_slave_bank.sv
logic/wb_host_ctrl.sv
logic/wb_host_top.sv
tb/tb_clock_gen.sv
tb/wb_host_tb.sv

// ==== tb/tb_clock_gen.sv ====
// Free-running 100 ns clock and an active-high reset held for 8 cycles
// Reset is released on a falling edge
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;  // Half of the 100 ns period
        end
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;  // Away from the rising edge
    end

endmodule

`default_nettype wire

// ==== tb/wb_host_tb.sv ====
// Self-checking testbench for wb_host_top, one classic access at a time
// Inputs change on the falling edge, responses are sampled there too
`default_nettype none

`include "wb_host_settings.svh"

module wb_host_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_ACCESSES = 200;
    localparam int HOLD_CYCLES     = 20;
    localparam int SETTLE_CYCLES   = 4;
    localparam int PATTERN_READS   = 4;
    // Reset sweep, write/read pairs, pattern reads, error cases, sweep, random, recovery
    localparam int ACCESS_COUNT = 4 * `WB_SLAVE_COUNT + PATTERN_READS
                                  + 2 * (15 - `WB_SLAVE_COUNT) + 3 + RANDOM_ACCESSES + 1;
    localparam int WATCHDOG_LIMIT = ACCESS_COUNT * 6 + HOLD_CYCLES + SETTLE_CYCLES + 200;
    localparam wb_pattern_pkg::pattern_t RESET_PATTERN = `WB_PATTERN_RESET;

    logic                 clk;
    logic                 rst;
    wb_bus_pkg::wb_addr_t adr;
    wb_bus_pkg::wb_data_t dat_w;
    logic                 we;
    logic                 cyc;
    logic                 stb;
    wb_bus_pkg::wb_data_t dat_r;
    logic                 ack;
    logic                 err;

    // Reference state
    wb_bus_pkg::wb_data_t     shadow_bank [16];
    wb_pattern_pkg::pattern_t shadow_pat;
    logic [31:0]              rng_state;

    // Access in flight and its expected {err, data}
    logic                 pend_valid;
    logic                 pend_we;
    wb_bus_pkg::wb_addr_t pend_adr;
    wb_bus_pkg::wb_data_t pend_wdata;
    logic [32:0]          pend_exp;
    int                   resp_count;
    logic                 hold_mode;
    int                   hold_errs;

    tb_clock_gen i_tb_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    wb_host_top i_wb_host_top (
        .clk     (clk),
        .rst     (rst),
        .adr_i   (adr),
        .dat_w_i (dat_w),
        .we_i    (we),
        .cyc_i   (cyc),
        .stb_i   (stb),
        .dat_r_o (dat_r),
        .ack_o   (ack),
        .err_o   (err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    // Left shift by one, XOR of bits 191, 159 and 127 enters at bit 0
    function automatic wb_pattern_pkg::pattern_t step_pattern(
        input wb_pattern_pkg::pattern_t s
    );
        logic feedback;
        feedback = s[191] ^ s[159] ^ s[127];
        return (s << 1) | wb_pattern_pkg::pattern_t'(feedback);
    endfunction

    function automatic wb_bus_pkg::wb_addr_t slot_address(input int idx);
        return wb_bus_pkg::wb_addr_t'(idx) << 4;
    endfunction

    // Expected {err, data} of one access
    // pat holds the generator state before the first strobed edge
    function automatic logic [32:0] ref_response(input wb_bus_pkg::wb_addr_t a, input logic w,
                                                 input wb_pattern_pkg::pattern_t pat);
        logic [3:0]               idx;
        wb_pattern_pkg::pattern_t two_steps;
        logic [32:0]              result;
        idx       = a[7:4];
        two_steps = step_pattern(step_pattern(pat));
        if (a[31:8] != 24'h0) begin
            result = {1'b1, 32'h0};
        end else if (int'(idx) < `WB_SLAVE_COUNT) begin
            result = w ? {1'b0, 32'h0} : {1'b0, shadow_bank[idx]};
        end else if (idx == 4'hF && !w) begin
            result = {1'b0, two_steps[31:0]};  // Sampled on the third edge
        end else begin
            result = {1'b1, 32'h0};
        end
        return result;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Called on a falling edge, returns one falling edge after the strobe drops
    task automatic do_access(input wb_bus_pkg::wb_addr_t a, input logic w,
                             input wb_bus_pkg::wb_data_t d);
        int start_count;
        start_count = resp_count;
        pend_adr    = a;
        pend_we     = w;
        pend_wdata  = d;
        pend_exp    = ref_response(a, w, shadow_pat);
        pend_valid  = 1'b1;
        adr         = a;
        we          = w;
        dat_w       = d;
        cyc         = 1'b1;
        stb         = 1'b1;
        wait (resp_count != start_count);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge clk);
    endtask

    // Generator model follows the strobe the testbench drives
    always @(posedge clk) begin
        if (cyc && stb) begin
            shadow_pat = step_pattern(shadow_pat);
        end
    end

    initial begin : compare_responses
        forever begin
            @(negedge clk);
            if (!rst && (ack || err)) begin
                if (hold_mode) begin
                    if (err) begin
                        hold_errs++;
                    end
                end else if (!pend_valid) begin
                    stop_with_error("An ack or err pulse arrived with no access pending");
                end else begin
                    check_value("err_o", 32'(err), 32'(pend_exp[32]));
                    check_value("ack_o", 32'(ack), 32'(!pend_exp[32]));
                    if (!pend_exp[32] && !pend_we) begin
                        check_value("dat_r_o", dat_r, pend_exp[31:0]);
                    end
                    if (!pend_exp[32] && pend_we) begin
                        shadow_bank[pend_adr[7:4]] = pend_wdata;  // Write has landed
                    end
                    pend_valid = 1'b0;
                    resp_count++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < WATCHDOG_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_error("The run went past its cycle limit without finishing");
    end

    initial begin : stimulus
        logic [31:0]          r;
        wb_bus_pkg::wb_data_t wdata;
        adr        = '0;
        dat_w      = '0;
        we         = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        rng_state  = 32'd59;
        pend_valid = 1'b0;
        pend_we    = 1'b0;
        pend_adr   = '0;
        pend_wdata = '0;
        pend_exp   = '0;
        resp_count = 0;
        hold_mode  = 1'b0;
        hold_errs  = 0;
        shadow_pat = RESET_PATTERN;
        for (int j = 0; j < 16; j++) begin
            shadow_bank[j] = (j < `WB_SLAVE_COUNT) ?
                RESET_PATTERN[31:0] + 32'(j) * `WB_BANK_STRIDE : 32'h0;
        end

        @(negedge rst);
        check_value("ack_o", 32'(ack), 32'h0);
        check_value("err_o", 32'(err), 32'h0);
        check_value("dat_r_o", dat_r, 32'h0);

        for (int i = 0; i < `WB_SLAVE_COUNT; i++) begin
            do_access(slot_address(i), 1'b0, '0);  // Reset contents
        end
        for (int i = 0; i < `WB_SLAVE_COUNT; i++) begin
            next_random(wdata);
            do_access(slot_address(i), 1'b1, wdata);
            do_access(slot_address(i), 1'b0, '0);
        end
        repeat (PATTERN_READS) do_access(slot_address(15), 1'b0, '0);

        // Error cases, bank must stay as it was
        for (int i = `WB_SLAVE_COUNT; i < 15; i++) begin
            do_access(slot_address(i), 1'b0, '0);
            next_random(wdata);
            do_access(slot_address(i), 1'b1, wdata);
        end
        do_access(32'h0000_0100, 1'b0, '0);
        do_access(32'h8000_0010, 1'b1, 32'hDEAD_BEEF);
        do_access(slot_address(15), 1'b1, 32'h0BAD_F00D);
        for (int i = 0; i < `WB_SLAVE_COUNT; i++) begin
            do_access(slot_address(i), 1'b0, '0);
        end

        for (int n = 0; n < RANDOM_ACCESSES; n++) begin
            next_random(r);
            next_random(wdata);
            if (r[2:0] == 3'd7) begin
                do_access(slot_address(15), 1'b0, '0);
            end else begin
                do_access(slot_address(int'(r[15:8]) % `WB_SLAVE_COUNT), r[16], wdata);
            end
        end

        // Strobe held far past the timeout
        hold_errs = 0;
        hold_mode = 1'b1;
        adr       = slot_address(3);
        we        = 1'b0;
        cyc       = 1'b1;
        stb       = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        repeat (SETTLE_CYCLES) @(negedge clk);
        hold_mode = 1'b0;
        check_value("err_o pulses while held", (hold_errs > 0) ? 32'd1 : 32'd0, 32'd1);
        do_access(slot_address(3), 1'b0, '0);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
